//--- Bender.yml
package:
  name: gpu_frontend

sources:
  - verilog/gpu_frontend_pkg.sv
  - verilog/warp_pc_table.sv
  - verilog/warp_fetch.sv
  - verilog/inst_decode.sv
  - verilog/inst_buffer.sv
  - verilog/gpu_frontend.sv
  - target: test
    files:
      - verif/gpu_frontend_tb.sv

//--- gpu_frontend.f
verilog/gpu_frontend_pkg.sv
verilog/warp_pc_table.sv
verilog/warp_fetch.sv
verilog/inst_decode.sv
verilog/inst_buffer.sv
verilog/gpu_frontend.sv
verif/gpu_frontend_tb.sv

//--- verif/gpu_frontend_tb.sv
/*
 * Testbench for the warp front end. It models the instruction memory and the host,
 * runs directed tests and checks every decoded instruction leaving the buffer.
 */
module gpu_frontend_tb import gpu_frontend_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;  // Longest run is about 600 cycles
  localparam int MEM_WORDS      = 256;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          cfg_req;
  warp_id_t      cfg_warp;
  addr_t         cfg_pc;
  logic          cfg_ack;
  logic          imem_req;
  addr_t         imem_addr;
  logic          imem_ack;
  inst_word_t    imem_rdata;
  logic          resolve_valid;
  warp_id_t      resolve_warp;
  addr_t         resolve_pc;
  logic          ib_valid;
  decoded_inst_t ib_inst;
  logic          ib_ready;

  inst_word_t prog [MEM_WORDS];
  integer     seed = 8023;
  int         delay;
  int         cycles = 0;

  gpu_frontend u_dut (
    .clk, .rst_n,
    .cfg_req, .cfg_warp, .cfg_pc, .cfg_ack,
    .imem_req, .imem_addr, .imem_ack, .imem_rdata,
    .resolve_valid, .resolve_warp, .resolve_pc,
    .ib_valid, .ib_inst, .ib_ready
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic check_eq(input string test, input string what,
                          input logic [95:0] exp, input logic [95:0] act);
    assert (act === exp) else begin
      $display("FAIL %s %s: expected %h, actual %h", test, what, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input string test, input logic cond, input string msg);
    assert (cond) else begin
      $display("Error in %s: %s", test, msg);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Instruction encoders, one per RV32 format
  function automatic inst_word_t enc_r(reg_idx_t rd, logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
    return {7'b0, rs2, rs1, f3, rd, OPC_ARITH};
  endfunction

  function automatic inst_word_t enc_i(opcode_t opc, reg_idx_t rd, logic [2:0] f3,
                                       reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_word_t enc_s(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                       logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic inst_word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                       logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_word_t enc_j(reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic decoded_inst_t expect_fields(addr_t pc, warp_id_t w, opcode_t opc,
                                                  reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                                  logic [2:0] f3, imm_t imm);
    decoded_inst_t e;
    e = '0;
    e.pc     = pc;
    e.warp   = w;
    e.opcode = opc;
    e.rd     = rd;
    e.rs1    = rs1;
    e.rs2    = rs2;
    e.funct3 = f3;
    e.imm    = imm;
    return e;
  endfunction

  // Every program ends in this branch so its warp parks in STALLED
  function automatic decoded_inst_t stop_fields(addr_t pc, warp_id_t w);
    return expect_fields(pc, w, OPC_BRANCH, 5'd0, 5'd1, 5'd2, 3'd0, 32'd16);
  endfunction

  task automatic put_inst(input addr_t a, input inst_word_t w);
    prog[a[9:2]] = w;
  endtask

  task automatic put_stop(input addr_t a);
    put_inst(a, enc_b(3'd0, 5'd1, 5'd2, 13'd16));
  endtask

  task automatic launch_warp(input warp_id_t w, input addr_t pc);
    @(negedge clk);
    cfg_warp = w;
    cfg_pc   = pc;
    cfg_req  = 1'b1;
    while (!cfg_ack) @(negedge clk);
    cfg_req = 1'b0;
    while (cfg_ack) @(negedge clk);
  endtask

  task automatic resolve(input warp_id_t w, input addr_t pc);
    @(negedge clk);
    resolve_valid = 1'b1;
    resolve_warp  = w;
    resolve_pc    = pc;
    @(negedge clk);
    resolve_valid = 1'b0;
  endtask

  // One pop from the buffer, ready held for a single edge
  task automatic take_inst(output decoded_inst_t d);
    @(negedge clk);
    while (!ib_valid) @(negedge clk);
    d        = ib_inst;
    ib_ready = 1'b1;
    @(negedge clk);
    ib_ready = 1'b0;
  endtask

  task automatic expect_next(input string test, input decoded_inst_t exp);
    decoded_inst_t got;
    take_inst(got);
    check_eq(test, "ib_inst", exp, got);
  endtask

  task automatic check_idle(input string test, input int n);
    repeat (n) begin
      @(negedge clk);
      check_true(test, !ib_valid, "an instruction appeared while the warp was stalled");
    end
  endtask

  // Instruction memory, four-phase with a random delay before ack
  initial begin
    imem_ack   = 1'b0;
    imem_rdata = '0;
    forever begin
      @(negedge clk);
      if (imem_req) begin
        delay = {$random(seed)} % 4;
        repeat (delay) @(negedge clk);
        check_true("imem", imem_addr < 32'h400, "instruction fetch outside program memory");
        imem_rdata = prog[imem_addr[9:2]];
        imem_ack   = 1'b1;
        while (imem_req) @(negedge clk);
        imem_ack = 1'b0;
      end
    end
  end

  task automatic test_straight_line();
    put_inst(32'h000, enc_r(5'd3, 3'd0, 5'd1, 5'd2));
    put_inst(32'h004, enc_i(OPC_ARITHI, 5'd5, 3'd0, 5'd4, 12'hFFB));
    put_inst(32'h008, enc_i(OPC_LOAD, 5'd6, 3'd2, 5'd7, 12'h010));
    put_inst(32'h00C, enc_s(3'd2, 5'd9, 5'd8, 12'hFF8));
    put_inst(32'h010, {20'h12345, 5'd10, OPC_LUI});
    put_stop(32'h014);
    launch_warp(2'd0, 32'h000);
    expect_next("straight_line", expect_fields(32'h000, 2'd0, OPC_ARITH, 3, 1, 2, 0, 0));
    expect_next("straight_line",
                expect_fields(32'h004, 2'd0, OPC_ARITHI, 5, 4, 0, 0, 32'hFFFF_FFFB));
    expect_next("straight_line", expect_fields(32'h008, 2'd0, OPC_LOAD, 6, 7, 0, 2, 32'd16));
    expect_next("straight_line",
                expect_fields(32'h00C, 2'd0, OPC_STORE, 0, 9, 8, 2, 32'hFFFF_FFF8));
    expect_next("straight_line",
                expect_fields(32'h010, 2'd0, OPC_LUI, 10, 0, 0, 0, 32'h1234_5000));
    expect_next("straight_line", stop_fields(32'h014, 2'd0));
  endtask

  task automatic test_jal_redirect();
    put_inst(32'h100, enc_j(5'd1, 21'd16));        // Forward to 0x110
    put_inst(32'h110, enc_j(5'd0, 21'h1F_FFF4));   // Back by 12 to 0x104
    put_inst(32'h104, enc_i(OPC_ARITHI, 5'd2, 3'd0, 5'd2, 12'd1));
    put_stop(32'h108);
    launch_warp(2'd1, 32'h100);
    expect_next("jal_redirect", expect_fields(32'h100, 2'd1, OPC_JAL, 1, 0, 0, 0, 32'd16));
    expect_next("jal_redirect",
                expect_fields(32'h110, 2'd1, OPC_JAL, 0, 0, 0, 0, 32'hFFFF_FFF4));
    expect_next("jal_redirect", expect_fields(32'h104, 2'd1, OPC_ARITHI, 2, 2, 0, 0, 32'd1));
    expect_next("jal_redirect", stop_fields(32'h108, 2'd1));
  endtask

  task automatic test_branch_resolve();
    put_inst(32'h200, enc_b(3'd0, 5'd3, 5'd4, 13'h1FF8));
    put_inst(32'h240, enc_r(5'd6, 3'd0, 5'd3, 5'd4));
    put_inst(32'h244, enc_i(OPC_JALR, 5'd1, 3'd0, 5'd5, 12'h020));
    put_stop(32'h280);
    launch_warp(2'd2, 32'h200);
    expect_next("branch_resolve",
                expect_fields(32'h200, 2'd2, OPC_BRANCH, 0, 3, 4, 0, 32'hFFFF_FFF8));
    check_idle("branch_resolve", 20);
    resolve(2'd2, 32'h240);
    expect_next("branch_resolve", expect_fields(32'h240, 2'd2, OPC_ARITH, 6, 3, 4, 0, 0));
    expect_next("branch_resolve", expect_fields(32'h244, 2'd2, OPC_JALR, 1, 5, 0, 0, 32'd32));
    check_idle("branch_resolve", 20);                 // JALR waits like a branch
    resolve(2'd2, 32'h280);
    expect_next("branch_resolve", stop_fields(32'h280, 2'd2));
  endtask

  task automatic test_multi_warp();
    decoded_inst_t got;
    decoded_inst_t exp;
    addr_t         pc;
    int            seen [NUM_WARPS];
    for (int w = 0; w < NUM_WARPS; w++) begin
      seen[w] = 0;
      for (int k = 0; k < 3; k++) begin
        put_inst(32'h300 + 32'h20 * w + 4 * k,
                 enc_i(OPC_ARITHI, reg_idx_t'(w + 1), 3'd0, reg_idx_t'(w), 12'(k)));
      end
      put_stop(32'h30C + 32'h20 * w);
    end
    for (int w = 0; w < NUM_WARPS; w++) launch_warp(warp_id_t'(w), 32'h300 + 32'h20 * w);
    repeat (4 * NUM_WARPS) begin
      take_inst(got);
      check_true("multi_warp", seen[got.warp] < 4, "a warp ran past the end of its program");
      pc = 32'h300 + 32'h20 * got.warp + 4 * seen[got.warp];
      if (seen[got.warp] < 3) begin
        exp = expect_fields(pc, got.warp, OPC_ARITHI, reg_idx_t'(got.warp + 1),
                            reg_idx_t'(got.warp), 0, 0, seen[got.warp]);
      end else begin
        exp = stop_fields(pc, got.warp);
      end
      check_eq("multi_warp", "ib_inst", exp, got);
      seen[got.warp]++;
    end
  endtask

  task automatic test_back_pressure();
    int high_cycles;
    high_cycles = 0;
    for (int k = 0; k < 7; k++) begin
      put_inst(32'h380 + 4 * k, enc_i(OPC_ARITHI, 5'd7, 3'd1, 5'd8, 12'(k + 1)));
    end
    put_stop(32'h39C);
    launch_warp(2'd0, 32'h380);
    while (high_cycles < 10) begin                    // Issue side held off meanwhile
      @(negedge clk);
      if (ib_valid) high_cycles++;
    end
    for (int k = 0; k < 7; k++) begin
      expect_next("back_pressure",
                  expect_fields(32'h380 + 4 * k, 2'd0, OPC_ARITHI, 7, 8, 0, 1, k + 1));
    end
    expect_next("back_pressure", stop_fields(32'h39C, 2'd0));
    check_idle("back_pressure", 10);
  endtask

  task automatic test_illegal();
    decoded_inst_t exp;
    put_inst(32'h3C0, enc_r(5'd9, 3'd7, 5'd10, 5'd11));
    put_inst(32'h3C4, 32'hABCD_E07F);                 // Opcode 7'h7f is not defined
    put_stop(32'h3E0);
    exp = expect_fields(32'h3C4, 2'd3, 7'h7F, 0, 0, 0, 0, 0);
    exp.illegal = 1'b1;
    launch_warp(2'd3, 32'h3C0);
    expect_next("illegal", expect_fields(32'h3C0, 2'd3, OPC_ARITH, 9, 10, 11, 7, 0));
    expect_next("illegal", exp);
    check_idle("illegal", 20);
    resolve(2'd3, 32'h3E0);
    expect_next("illegal", stop_fields(32'h3E0, 2'd3));
  endtask

  initial begin
    rst_n         = 1'b0;
    cfg_req       = 1'b0;
    cfg_warp      = '0;
    cfg_pc        = '0;
    resolve_valid = 1'b0;
    resolve_warp  = '0;
    resolve_pc    = '0;
    ib_ready      = 1'b0;
    // Fill words carry an unknown opcode so a stray fetch decodes as illegal
    for (int i = 0; i < MEM_WORDS; i++) prog[i] = {~8'(i), 8'h5A, 8'(i), 8'h7F};
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_eq("reset", "imem_req", 0, imem_req);
    check_eq("reset", "cfg_ack", 0, cfg_ack);
    check_eq("reset", "ib_valid", 0, ib_valid);
    test_straight_line();
    test_jal_redirect();
    test_branch_resolve();
    test_multi_warp();
    test_back_pressure();
    test_illegal();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- verilog/gpu_frontend.sv
/*
 * Warp front end top: PC table, fetch, decode and instruction buffer.
 */
module gpu_frontend import gpu_frontend_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cfg_req,
  input  warp_id_t      cfg_warp,
  input  addr_t         cfg_pc,
  output logic          cfg_ack,
  output logic          imem_req,
  output addr_t         imem_addr,
  input  logic          imem_ack,
  input  inst_word_t    imem_rdata,
  input  logic          resolve_valid,
  input  warp_id_t      resolve_warp,
  input  addr_t         resolve_pc,
  output logic          ib_valid,
  output decoded_inst_t ib_inst,
  input  logic          ib_ready
);

  logic [NUM_WARPS-1:0]  warp_ready;
  addr_t [NUM_WARPS-1:0] warp_pc;
  logic                  sel_valid;
  warp_id_t              sel_warp;
  logic                  fd_valid;
  logic                  fd_ready;
  fetch_pkt_t            fd_pkt;
  logic                  db_valid;
  logic                  db_ready;
  decoded_inst_t         db_inst;
  logic                  upd_valid;
  pc_update_t            upd;

  warp_pc_table u_pc_table (
    .clk, .rst_n,
    .cfg_req, .cfg_warp, .cfg_pc, .cfg_ack,
    .sel_valid, .sel_warp,
    .upd_valid, .upd,
    .resolve_valid, .resolve_warp, .resolve_pc,
    .warp_ready, .warp_pc
  );

  warp_fetch u_fetch (
    .clk, .rst_n,
    .warp_ready, .warp_pc,
    .sel_valid, .sel_warp,
    .imem_req, .imem_addr, .imem_ack, .imem_rdata,
    .fd_valid, .fd_pkt, .fd_ready
  );

  inst_decode u_decode (
    .clk, .rst_n,
    .fd_valid, .fd_pkt, .fd_ready,
    .db_valid, .db_inst, .db_ready,
    .upd_valid, .upd
  );

  inst_buffer u_ibuf (
    .clk, .rst_n,
    .db_valid, .db_inst, .db_ready,
    .ib_valid, .ib_inst, .ib_ready
  );

endmodule

//--- verilog/gpu_frontend_pkg.sv
/*
 * Shared types for the warp front end of the SIMT core.
 * Widths, RV32 opcode values and the structs passed between blocks.
 */
package gpu_frontend_pkg;

  localparam int NUM_WARPS = 4;
  localparam int IB_DEPTH  = 4;

  typedef logic [31:0] addr_t;       // Byte address
  typedef logic [31:0] inst_word_t;  // Raw instruction word
  typedef logic [1:0]  warp_id_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] imm_t;        // Sign-extended immediate
  typedef logic [6:0]  opcode_t;

  // RV32 base opcodes, NOP sits in custom-0
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_ARITHI = 7'b0010011;
  localparam opcode_t OPC_ARITH  = 7'b0110011;
  localparam opcode_t OPC_NOP    = 7'b0001011;

  typedef enum logic [1:0] {
    IDLE,     // Not launched
    READY,    // May be picked by fetch
    BUSY,     // One instruction in flight
    STALLED   // Waiting for a resolved PC
  } warp_state_t;

  typedef enum logic {
    DEC_IDLE,
    DEC_OUT
  } dec_state_t;

  typedef struct packed {
    warp_id_t   warp;
    addr_t      pc;
    inst_word_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    addr_t       pc;
    warp_id_t    warp;
    opcode_t     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  funct3;
    imm_t        imm;
    logic        illegal;
  } decoded_inst_t;

  typedef struct packed {
    warp_id_t warp;
    addr_t    next_pc;
    logic     stall;
  } pc_update_t;

endpackage

//--- verilog/inst_buffer.sv
/*
 * Instruction buffer: small circular FIFO of decoded instructions
 * between decode and the issue stage.
 */
module inst_buffer import gpu_frontend_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          db_valid,
  input  decoded_inst_t db_inst,
  output logic          db_ready,
  output logic          ib_valid,
  output decoded_inst_t ib_inst,
  input  logic          ib_ready
);

  decoded_inst_t                 mem [IB_DEPTH];
  logic [$clog2(IB_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(IB_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(IB_DEPTH+1)-1:0] count;
  logic                          push;
  logic                          pop;

  assign db_ready = (count != IB_DEPTH);
  assign ib_valid = (count != 0);
  assign ib_inst  = mem[rd_ptr];
  assign push     = db_valid && db_ready;
  assign pop      = ib_valid && ib_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == IB_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == IB_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= db_inst;
  end

endmodule

//--- verilog/inst_decode.sv
/*
 * Instruction decode: splits an RV32-style word into its fields,
 * sign-extends the immediate and computes the warp's next PC.
 */
module inst_decode import gpu_frontend_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          fd_valid,
  input  fetch_pkt_t    fd_pkt,
  output logic          fd_ready,
  output logic          db_valid,
  output decoded_inst_t db_inst,
  input  logic          db_ready,
  output logic          upd_valid,
  output pc_update_t    upd
);

  dec_state_t    state;
  decoded_inst_t inst_q;
  pc_update_t    upd_q;

  function automatic decoded_inst_t decode(fetch_pkt_t pkt);
    decoded_inst_t d;
    inst_word_t    w;
    w        = pkt.inst;
    d        = '0;  // Unused fields stay zero
    d.pc     = pkt.pc;
    d.warp   = pkt.warp;
    d.opcode = w[6:0];
    case (w[6:0])
      OPC_LUI, OPC_AUIPC: begin  // U-type
        d.rd  = w[11:7];
        d.imm = {w[31:12], 12'b0};
      end
      OPC_JAL: begin  // J-type
        d.rd  = w[11:7];
        d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR, OPC_LOAD, OPC_ARITHI: begin  // I-type
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.funct3 = w[14:12];
        d.imm    = {{20{w[31]}}, w[31:20]};
      end
      OPC_BRANCH: begin  // B-type
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = w[14:12];
        d.imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      OPC_STORE: begin  // S-type
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = w[14:12];
        d.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      OPC_ARITH: begin  // R-type
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = w[14:12];
      end
      OPC_NOP: begin
      end
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  // Where the warp continues after this instruction
  function automatic pc_update_t next_pc(decoded_inst_t d);
    pc_update_t u;
    u.warp    = d.warp;
    u.next_pc = d.pc + 32'd4;
    u.stall   = 1'b0;
    if (d.illegal || d.opcode == OPC_BRANCH || d.opcode == OPC_JALR) begin
      u.stall   = 1'b1;    // Target comes from execute
      u.next_pc = d.pc;
    end else if (d.opcode == OPC_JAL) begin
      u.next_pc = d.pc + d.imm;
    end
    return u;
  endfunction

  assign fd_ready  = (state == DEC_IDLE);
  assign db_valid  = (state == DEC_OUT);
  assign db_inst   = inst_q;
  assign upd_valid = (state == DEC_OUT) && db_ready;  // Only once the buffer takes it
  assign upd       = upd_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DEC_IDLE;
    end else begin
      case (state)
        DEC_IDLE: if (fd_valid) state <= DEC_OUT;
        DEC_OUT:  if (db_ready) state <= DEC_IDLE;
        default:  state <= DEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DEC_IDLE && fd_valid) begin
      inst_q <= decode(fd_pkt);
      upd_q  <= next_pc(decode(fd_pkt));
    end
  end

endmodule

//--- verilog/warp_fetch.sv
/*
 * Warp fetch: round-robin pick among ready warps and a four-phase
 * instruction memory read into a single packet register for decode.
 */
module warp_fetch import gpu_frontend_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [NUM_WARPS-1:0]  warp_ready,
  input  addr_t [NUM_WARPS-1:0] warp_pc,
  output logic                  sel_valid,
  output warp_id_t              sel_warp,
  output logic                  imem_req,
  output addr_t                 imem_addr,
  input  logic                  imem_ack,
  input  inst_word_t            imem_rdata,
  output logic                  fd_valid,
  output fetch_pkt_t            fd_pkt,
  input  logic                  fd_ready
);

  typedef enum logic {
    F_IDLE,
    F_REQ
  } fetch_state_t;

  fetch_state_t state;
  warp_id_t     last_grant;
  warp_id_t     pick;
  logic         pick_found;
  warp_id_t     req_warp;   // Warp of the outstanding read
  addr_t        req_addr;

  // Search starts just after the last granted warp
  always_comb begin
    warp_id_t idx;
    pick_found = 1'b0;
    pick       = last_grant;
    for (int i = 1; i <= NUM_WARPS; i++) begin
      idx = warp_id_t'(last_grant + i);
      if (!pick_found && warp_ready[idx]) begin
        pick_found = 1'b1;
        pick       = idx;
      end
    end
  end

  // New read only with ack low and room for its packet
  assign sel_valid = (state == F_IDLE) && !imem_ack && (!fd_valid || fd_ready) && pick_found;
  assign sel_warp  = pick;

  assign imem_req  = (state == F_REQ);
  assign imem_addr = req_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= F_IDLE;
      last_grant <= warp_id_t'(NUM_WARPS - 1);  // Warp 0 wins first
      fd_valid   <= 1'b0;
    end else begin
      if (fd_valid && fd_ready) fd_valid <= 1'b0;
      case (state)
        F_IDLE: begin
          if (sel_valid) begin
            last_grant <= pick;
            state      <= F_REQ;
          end
        end
        F_REQ: begin
          if (imem_ack) begin
            fd_valid <= 1'b1;
            state    <= F_IDLE;  // Drops req, memory then drops ack
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sel_valid) begin
      req_warp <= pick;
      req_addr <= warp_pc[pick];
    end
    if (state == F_REQ && imem_ack) begin
      fd_pkt.warp <= req_warp;
      fd_pkt.pc   <= req_addr;
      fd_pkt.inst <= imem_rdata;
    end
  end

endmodule

//--- verilog/warp_pc_table.sv
/*
 * Warp PC table: program counter and run state for every warp.
 * Applies host launches, fetch selections, decode updates and branch resolves.
 */
module warp_pc_table import gpu_frontend_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cfg_req,
  input  warp_id_t                    cfg_warp,
  input  addr_t                       cfg_pc,
  output logic                        cfg_ack,
  input  logic                        sel_valid,
  input  warp_id_t                    sel_warp,
  input  logic                        upd_valid,
  input  pc_update_t                  upd,
  input  logic                        resolve_valid,
  input  warp_id_t                    resolve_warp,
  input  addr_t                       resolve_pc,
  output logic [NUM_WARPS-1:0]        warp_ready,
  output addr_t [NUM_WARPS-1:0]       warp_pc
);

  warp_state_t state [NUM_WARPS];
  logic        launch;

  assign launch = cfg_req && !cfg_ack;  // First cycle the request is seen

  // Four-phase ack toward the host
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ack <= 1'b0;
    end else if (launch) begin
      cfg_ack <= 1'b1;
    end else if (!cfg_req) begin
      cfg_ack <= 1'b0;
    end
  end

  // Run state, one event per warp per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NUM_WARPS; w++) state[w] <= IDLE;
    end else begin
      for (int w = 0; w < NUM_WARPS; w++) begin
        if (launch && cfg_warp == w) begin
          state[w] <= READY;
        end else if (upd_valid && upd.warp == w) begin
          state[w] <= upd.stall ? STALLED : READY;
        end else if (resolve_valid && resolve_warp == w && state[w] == STALLED) begin
          state[w] <= READY;
        end else if (sel_valid && sel_warp == w) begin
          state[w] <= BUSY;  // Blocks a second fetch of this warp
        end
      end
    end
  end

  // PC values follow the same priority as the state
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WARPS; w++) begin
      if (launch && cfg_warp == w) begin
        warp_pc[w] <= cfg_pc;
      end else if (upd_valid && upd.warp == w) begin
        if (!upd.stall) warp_pc[w] <= upd.next_pc;
      end else if (resolve_valid && resolve_warp == w && state[w] == STALLED) begin
        warp_pc[w] <= resolve_pc;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < NUM_WARPS; w++) warp_ready[w] = (state[w] == READY);
  end

endmodule
